// ==== include/armExec_params.svh ====
`ifndef ARMEXEC_PARAMS_SVH
`define ARMEXEC_PARAMS_SVH

// input credits the sender starts with, also the queue depth
`define EXEC_QUEUE_DEPTH 4

// results the stage may have in flight downstream
`define EXEC_OUT_CREDITS 2

// operand width
`define EXEC_DATA_W 32

`endif

// ==== src/armExecPkg.sv ====
`default_nettype none

`include "armExec_params.svh"

package armExecPkg;

    // data-processing opcodes, ARM encoding order
    typedef enum logic [3:0] {
        opAnd, opEor, opSub, opRsb, opAdd, opAdc, opSbc, opRsc,
        opTst, opTeq, opCmp, opCmn, opOrr, opMov, opBic, opMvn
    } aluOpE;

    typedef enum logic [1:0] {shLsl, shLsr, shAsr, shRor} shiftTypeE;

    // condition field, AL is the last defined code
    typedef enum logic [3:0] {
        condEq, condNe, condCs, condCc, condMi, condPl, condVs, condVc,
        condHi, condLs, condGe, condLt, condGt, condLe, condAl
    } condE;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flagsT;

    typedef struct packed {
        aluOpE                   op;
        condE                    cond;
        logic                    setFlags;
        logic [`EXEC_DATA_W-1:0] srcA;
        logic [`EXEC_DATA_W-1:0] srcB;
        shiftTypeE               shiftType;
        logic [4:0]              shiftAmt;
        logic [3:0]              dest;
    } execOpT;

    typedef struct packed {
        logic [`EXEC_DATA_W-1:0] result;
        flagsT                   flags;
        logic [3:0]              dest;
        logic                    writeEn;
    } execResT;

endpackage

`default_nettype wire

// ==== src/opQueue.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "armExec_params.svh"

module opQueue (
    input  wire logic               clk,
    input  wire logic               arstN,
    input  wire logic               push,
    input  wire armExecPkg::execOpT pushOp,
    input  wire logic               pop,
    output armExecPkg::execOpT      popOp,
    output logic                    notEmpty,
    output logic                    credit
);
    import armExecPkg::*;

    localparam int Depth = `EXEC_QUEUE_DEPTH;
    localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW  = $clog2(Depth + 1);

    execOpT            mem [Depth];
    logic [PtrW-1:0]   wrPtr;
    logic [PtrW-1:0]   rdPtr;
    logic [CntW-1:0]   count;

    assign popOp    = mem[rdPtr];
    assign notEmpty = (count != '0);

    // storage, written only on push
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushOp;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr  <= '0;
            rdPtr  <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back per entry leaving
            credit <= pop;
        end
    end

    // sender must hold a credit, consumer must check notEmpty
    assert property (@(posedge clk) disable iff (!arstN) push |-> count != CntW'(Depth));
    assert property (@(posedge clk) disable iff (!arstN) pop |-> count != '0);

endmodule

`default_nettype wire

// ==== src/barrelShifter.sv ====
`timescale 1ns/10ps
`default_nettype none

module barrelShifter (
    input  wire logic [31:0]          value,
    input  wire armExecPkg::shiftTypeE shiftType,
    input  wire logic [4:0]           shiftAmt,
    input  wire logic                 carryIn,
    output logic [31:0]               shifted,
    output logic                      carryOut
);
    import armExecPkg::*;

    // two copies side by side, a right shift of this gives the rotate
    logic [63:0] doubled;
    logic [63:0] rotated;

    assign doubled = {value, value};
    assign rotated = doubled >> shiftAmt;

    always_comb begin
        shifted  = value;
        carryOut = carryIn;
        case (shiftType)
            shLsl: begin
                // carry sits above bit 31 and picks up the last bit out
                {carryOut, shifted} = {carryIn, value} << shiftAmt;
            end
            shLsr: begin
                // carry sits below bit 0
                {shifted, carryOut} = {value, carryIn} >> shiftAmt;
            end
            shAsr: begin
                {shifted, carryOut} = $signed({value, carryIn}) >>> shiftAmt;
            end
            shRor: begin
                shifted = rotated[31:0];
                // by zero the old carry stays
                if (shiftAmt != 5'd0) begin
                    carryOut = rotated[31];
                end
            end
            default: begin
                shifted  = value;
                carryOut = carryIn;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/aluCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module aluCore (
    input  wire logic [31:0]       srcA,
    input  wire logic [31:0]       srcB,
    input  wire armExecPkg::aluOpE op,
    input  wire armExecPkg::flagsT flagsIn,
    input  wire logic              shiftCarry,
    output logic [31:0]            result,
    output armExecPkg::flagsT      flagsOut
);
    import armExecPkg::*;

    logic [31:0] addA;
    logic [31:0] addB;
    logic        carryIn;
    logic        isArith;
    logic [32:0] sum;
    logic        overflow;

    // ########################################
    // adder operand select
    // ########################################

    always_comb begin
        addA    = srcA;
        addB    = srcB;
        carryIn = 1'b0;
        isArith = 1'b1;
        case (op)
            opSub, opCmp: begin
                addB    = ~srcB;
                carryIn = 1'b1;
            end
            opRsb: begin
                addA    = srcB;
                addB    = ~srcA;
                carryIn = 1'b1;
            end
            opAdd, opCmn: begin
                carryIn = 1'b0;
            end
            opAdc: begin
                carryIn = flagsIn.c;
            end
            opSbc: begin
                addB    = ~srcB;
                carryIn = flagsIn.c;
            end
            opRsc: begin
                addA    = srcB;
                addB    = ~srcA;
                carryIn = flagsIn.c;
            end
            default: begin
                isArith = 1'b0;
            end
        endcase
    end

    // one shared 33-bit add
    assign sum = {1'b0, addA} + {1'b0, addB} + {32'd0, carryIn};

    // same-sign inputs, different-sign sum
    assign overflow = (addA[31] == addB[31]) && (sum[31] != addA[31]);

    // ########################################
    // result and NZCV
    // ########################################

    always_comb begin
        case (op)
            opAnd, opTst: result = srcA & srcB;
            opEor, opTeq: result = srcA ^ srcB;
            opOrr:        result = srcA | srcB;
            opMov:        result = srcB;
            opBic:        result = srcA & ~srcB;
            opMvn:        result = ~srcB;
            default:      result = sum[31:0];
        endcase
    end

    assign flagsOut.n = result[31];
    assign flagsOut.z = ~|result;
    // logical ops take the shifter carry and keep V
    assign flagsOut.c = isArith ? sum[32] : shiftCarry;
    assign flagsOut.v = isArith ? overflow : flagsIn.v;

endmodule

`default_nettype wire

// ==== src/flagUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module flagUnit (
    input  wire logic              clk,
    input  wire logic              arstN,
    input  wire armExecPkg::condE  cond,
    input  wire armExecPkg::flagsT flagsNew,
    input  wire logic              update,
    input  wire logic              forceUpdate,
    output armExecPkg::flagsT      flags,
    output logic                   passed
);
    import armExecPkg::*;

    // ARM condition table on the held flags
    always_comb begin
        case (cond)
            condEq:  passed = flags.z;
            condNe:  passed = !flags.z;
            condCs:  passed = flags.c;
            condCc:  passed = !flags.c;
            condMi:  passed = flags.n;
            condPl:  passed = !flags.n;
            condVs:  passed = flags.v;
            condVc:  passed = !flags.v;
            condHi:  passed = flags.c && !flags.z;
            condLs:  passed = !flags.c || flags.z;
            condGe:  passed = (flags.n == flags.v);
            condLt:  passed = (flags.n != flags.v);
            condGt:  passed = !flags.z && (flags.n == flags.v);
            condLe:  passed = flags.z || (flags.n != flags.v);
            default: passed = 1'b1;
        endcase
    end

    // compares arrive on forceUpdate, a failed op writes nothing
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flags <= '0;
        end else if (passed && (update || forceUpdate)) begin
            flags <= flagsNew;
        end
    end

    // an X here would poison every later condition
    assert property (@(posedge clk) disable iff (!arstN) !$isunknown(flags));

endmodule

`default_nettype wire

// ==== src/execUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "armExec_params.svh"

module execUnit (
    input  wire logic               clk,
    input  wire logic               arstN,
    input  wire logic               opValid,
    input  wire armExecPkg::execOpT opIn,
    output logic                    opCredit,
    output logic                    resValid,
    output armExecPkg::execResT     resOut,
    input  wire logic               resCredit
);
    import armExecPkg::*;

    localparam int OutCredits = `EXEC_OUT_CREDITS;
    localparam int CntW       = $clog2(OutCredits + 1);

    execOpT          qOp;
    logic            qNotEmpty;
    logic            pop;
    execOpT          s1Op;
    logic            s1Full;
    logic            resFull;
    logic            advance;
    logic [CntW-1:0] creditCnt;
    logic [31:0]     shifted;
    logic            shiftCarry;
    logic [31:0]     aluResult;
    flagsT           aluFlags;
    flagsT           curFlags;
    logic            passed;
    logic            isCompare;
    logic            writeFlags;

    opQueue queue (
        .clk(clk), .arstN(arstN), .push(opValid), .pushOp(opIn),
        .pop(pop), .popOp(qOp), .notEmpty(qNotEmpty), .credit(opCredit)
    );

    // ########################################
    // advance chain from back to front
    // ########################################

    assign resValid = resFull && (creditCnt != '0);
    assign advance  = s1Full && (!resFull || resValid);
    assign pop      = qNotEmpty && (!s1Full || advance);

    // stage two computed from the stage one register
    barrelShifter shifter (
        .value(s1Op.srcB), .shiftType(s1Op.shiftType), .shiftAmt(s1Op.shiftAmt),
        .carryIn(curFlags.c), .shifted(shifted), .carryOut(shiftCarry)
    );

    aluCore alu (
        .srcA(s1Op.srcA), .srcB(shifted), .op(s1Op.op), .flagsIn(curFlags),
        .shiftCarry(shiftCarry), .result(aluResult), .flagsOut(aluFlags)
    );

    assign isCompare = s1Op.op inside {opTst, opTeq, opCmp, opCmn};

    flagUnit flagRegs (
        .clk(clk), .arstN(arstN), .cond(s1Op.cond), .flagsNew(aluFlags),
        .update(advance && s1Op.setFlags), .forceUpdate(advance && isCompare),
        .flags(curFlags), .passed(passed)
    );

    // flags as they stand after this op
    assign writeFlags = passed && (s1Op.setFlags || isCompare);

    always_ff @(posedge clk) begin
        if (pop) begin
            s1Op <= qOp;
        end
        if (advance) begin
            resOut.result  <= aluResult;
            resOut.flags   <= writeFlags ? aluFlags : curFlags;
            resOut.dest    <= s1Op.dest;
            resOut.writeEn <= passed && !isCompare;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            s1Full    <= 1'b0;
            resFull   <= 1'b0;
            creditCnt <= CntW'(OutCredits);
        end else begin
            s1Full  <= pop || (s1Full && !advance);
            resFull <= advance || (resFull && !resValid);
            case ({resValid, resCredit})
                2'b10:   creditCnt <= creditCnt - 1'b1;
                2'b01:   creditCnt <= creditCnt + 1'b1;
                default: creditCnt <= creditCnt;
            endcase
        end
    end

    // consumer returns only what it was sent
    assert property (@(posedge clk) disable iff (!arstN) creditCnt <= CntW'(OutCredits));
    assert property (@(posedge clk) disable iff (!arstN)
        (resCredit && !resValid) |-> creditCnt < CntW'(OutCredits));

endmodule

`default_nettype wire

// ==== bench/execMonitor.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "armExec_params.svh"

module execMonitor (
    input  wire logic                clk,
    input  wire logic                arstN,
    input  wire logic                resValid,
    input  wire armExecPkg::execResT resOut,
    input  wire logic                resCredit,
    input  wire logic                expPush,
    input  wire armExecPkg::execResT expRes,
    output int                       errors,
    output int                       received
);
    import armExecPkg::*;

    execResT expQ[$];
    execResT want;
    int      errCnt   = 0;
    int      gotCnt   = 0;
    int      sent     = 0;
    int      returned = 0;

    assign errors   = errCnt;
    assign received = gotCnt;

    always @(posedge clk) begin
        if (arstN) begin
            if (expPush) begin
                expQ.push_back(expRes);
            end
            if (resValid) begin
                sent++;
                gotCnt++;
                // credits returned before this edge
                if (sent > returned + `EXEC_OUT_CREDITS) begin
                    $display("more results sent than credits allow at %0t", $time);
                    errCnt++;
                end
                if (expQ.size() == 0) begin
                    $display("a result arrived with nothing outstanding at %0t", $time);
                    errCnt++;
                end else begin
                    want = expQ.pop_front();
                    if (resOut.writeEn !== want.writeEn || resOut.dest !== want.dest ||
                        resOut.flags !== want.flags || resOut.result !== want.result) begin
                        $display("ERROR %0t: result %0d got %h nzcv %b dest %h we %b",
                            $time, gotCnt, resOut.result, resOut.flags, resOut.dest,
                            resOut.writeEn);
                        $display("ERROR %0t: result %0d expected %h nzcv %b dest %h we %b",
                            $time, gotCnt, want.result, want.flags, want.dest, want.writeEn);
                        errCnt++;
                    end
                end
            end
            if (resCredit) begin
                returned++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/execUnitTb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "armExec_params.svh"

module execUnitTb;
    import armExecPkg::*;

    localparam int SendLimit  = 2000;
    localparam int DrainLimit = 1000;

    logic    clk;
    logic    arstN;
    logic    opValid;
    execOpT  opIn;
    logic    opCredit;
    logic    resValid;
    execResT resOut;
    logic    resCredit;
    logic    expPush;
    execResT expRes;
    int      errors;
    int      received;
    int      failures;
    execOpT  patOps[$];
    execResT patExp[$];

    execUnit UUT (
        .clk(clk), .arstN(arstN), .opValid(opValid), .opIn(opIn), .opCredit(opCredit),
        .resValid(resValid), .resOut(resOut), .resCredit(resCredit)
    );

    execMonitor monitor (
        .clk(clk), .arstN(arstN), .resValid(resValid), .resOut(resOut),
        .resCredit(resCredit), .expPush(expPush), .expRes(expRes),
        .errors(errors), .received(received)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // one operation and its expected record per data line
    task automatic loadPatterns();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] fOp, fCond, fSet, fA, fB, fSh;
        logic [31:0] fAmt, fDest, fRes, fNzcv, fWe;
        execOpT      op;
        execResT     res;
        fd = $fopen("bench/execPatterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file bench/execPatterns.txt");
            failures++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
                continue;
            end
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", fOp, fCond, fSet,
                fA, fB, fSh, fAmt, fDest, fRes, fNzcv, fWe);
            if (cnt != 11) begin
                $display("malformed pattern line: %s", line);
                failures++;
                continue;
            end
            op.op        = aluOpE'(fOp[3:0]);
            op.cond      = condE'(fCond[3:0]);
            op.setFlags  = fSet[0];
            op.srcA      = fA;
            op.srcB      = fB;
            op.shiftType = shiftTypeE'(fSh[1:0]);
            op.shiftAmt  = fAmt[4:0];
            op.dest      = fDest[3:0];
            res.result   = fRes;
            res.flags    = flagsT'(fNzcv[3:0]);
            res.dest     = fDest[3:0];
            res.writeEn  = fWe[0];
            patOps.push_back(op);
            patExp.push_back(res);
        end
        $fclose(fd);
    endtask

    // ########################################
    // sender with input credit tracking
    // ########################################

    initial begin
        int idx;
        int credits;
        int cycles;
        arstN    = 1'b0;
        opValid  = 1'b0;
        opIn     = '0;
        expPush  = 1'b0;
        expRes   = '0;
        failures = 0;
        loadPatterns();
        if (patOps.size() == 0) begin
            $display("no operations were loaded from the pattern file");
            failures++;
        end
        repeat (2) @(posedge clk);
        arstN <= 1'b1;

        idx     = 0;
        credits = `EXEC_QUEUE_DEPTH;
        cycles  = 0;
        while (idx < patOps.size() && cycles < SendLimit) begin
            @(posedge clk);
            cycles++;
            if (opCredit) begin
                credits++;
            end
            if (credits > `EXEC_QUEUE_DEPTH) begin
                $display("input credits above the queue depth at %0t", $time);
                failures++;
            end
            if (credits > 0) begin
                opValid <= 1'b1;
                opIn    <= patOps[idx];
                expPush <= 1'b1;
                expRes  <= patExp[idx];
                credits--;
                idx++;
            end else begin
                opValid <= 1'b0;
                expPush <= 1'b0;
            end
        end
        @(posedge clk);
        opValid <= 1'b0;
        expPush <= 1'b0;
        if (idx < patOps.size()) begin
            $display("sender timed out with %0d of %0d operations sent", idx, patOps.size());
            failures++;
        end

        // all results must drain
        cycles = 0;
        while (received < patOps.size() && cycles < DrainLimit) begin
            @(posedge clk);
            cycles++;
        end
        if (received != patOps.size()) begin
            $display("drain timed out with %0d of %0d results seen", received, patOps.size());
            failures++;
        end
        // a few idle cycles to catch stray results
        repeat (4) @(posedge clk);

        $display("errors: %0d result mismatches, %0d other failures", errors, failures);
        if (errors == 0 && failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // consumer side, credits go back after 0 to 3 idle cycles
    initial begin
        int owed;
        int delay;
        owed      = 0;
        delay     = 0;
        resCredit = 1'b0;
        void'($urandom(32'h756e9243));
        forever begin
            @(posedge clk);
            if (arstN && resValid) begin
                owed++;
            end
            if (owed > 0 && delay == 0) begin
                resCredit <= 1'b1;
                owed--;
                delay = $urandom % 4;
            end else begin
                resCredit <= 1'b0;
                if (delay > 0) begin
                    delay--;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/execPatterns.txt ====
# op cond s srcA srcB shift amt dest expResult expNzcv expWriteEn, all hex
# op and cond in ARM encoding, shift 0 LSL 1 LSR 2 ASR 3 ROR
4 e 1 00000001 00000002 0 00 1 00000003 0 1
4 e 1 ffffffff 00000001 0 00 2 00000000 6 1
5 e 1 00000005 00000006 0 00 3 0000000c 0 1
2 e 1 00000005 00000007 0 00 4 fffffffe 8 1
6 e 1 00000010 00000003 0 00 5 0000000c 2 1
7 e 1 00000001 00000004 0 00 6 00000003 2 1
4 e 1 7fffffff 00000001 0 00 7 80000000 9 1
d e 1 00000000 00000081 1 01 8 00000040 3 1
3 e 1 00000003 00000001 0 04 9 0000000d 2 1
c e 1 0000f000 80000001 3 01 a c000f000 a 1
1 e 1 12345678 12345678 0 00 b 00000000 6 1
0 e 1 ffffffff f0000000 2 04 c ff000000 8 1
f e 1 00000000 0001ffff 0 10 d 0000ffff 2 1
e e 0 ffffffff 0000000f 0 00 e fffffff0 2 1
a e 0 00000005 00000005 0 00 0 00000000 6 0
4 0 0 00000001 00000001 0 00 1 00000002 6 1
d 1 1 00000000 00000055 0 00 2 00000055 6 0
b e 0 7fffffff 00000001 0 00 3 80000000 9 0
8 e 0 0000000f 000000f0 0 00 4 00000000 5 0
9 e 0 80000000 00000000 0 00 5 80000000 9 0
4 a 1 00000001 00000001 0 00 6 00000002 0 1
2 b 1 00000003 00000001 0 00 7 00000002 0 0
a e 0 00000003 00000007 0 00 8 fffffffc 8 0
4 8 0 00000001 00000001 0 00 9 00000002 8 0
4 9 0 00000001 00000002 0 00 a 00000003 8 1
4 4 1 ffffffff ffffffff 0 00 b fffffffe a 1
6 2 1 00000000 00000000 0 00 c 00000000 6 1
5 e 1 00000001 00000001 0 00 d 00000003 0 1

// ==== armExec.f ====
+incdir+include
src/armExecPkg.sv
src/opQueue.sv
src/barrelShifter.sv
src/aluCore.sv
src/flagUnit.sv
src/execUnit.sv
bench/execMonitor.sv
bench/execUnitTb.sv

// ==== Makefile ====
BIN  := obj_dir/VexecUnitTb
SRCS := armExec.f $(wildcard src/*.sv bench/*.sv include/*.svh)

all: run

$(BIN): $(SRCS)
	verilator --binary --timing --assert -f armExec.f --top-module execUnitTb

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
